/* alu_unit.sv */
`include "issue_params.svh"

module alu_unit import issue_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   issue,
    input  logic [`XLEN-1:0]       op_a,
    input  logic [`XLEN-1:0]       op_b,
    input  logic [`XLEN-1:0]       imm_value,
    input  logic                   use_imm,
    input  alu_op_e                alu_op,
    input  logic [`REG_ADDR_W-1:0] dest,
    input  logic                   writes_dest,
    output logic                   result_valid,
    output logic [`REG_ADDR_W-1:0] result_dest,
    output logic [`XLEN-1:0]       result_data
);

    logic                   valid_q;
    logic [`XLEN-1:0]       a_q;
    logic [`XLEN-1:0]       b_q;
    alu_op_e                op_q;
    logic [`REG_ADDR_W-1:0] dest_q;
    logic [`XLEN-1:0]       alu_res;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q      <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            valid_q      <= issue && writes_dest;
            result_valid <= valid_q;
        end
    end

    // operand capture on issue.
    always_ff @(posedge clock) begin
        if (issue) begin
            a_q    <= op_a;
            b_q    <= use_imm ? imm_value : op_b;
            op_q   <= alu_op;
            dest_q <= dest;
        end
    end

    always_comb begin
        case (op_q)
            ALU_SUB: alu_res = a_q - b_q;
            ALU_AND: alu_res = a_q & b_q;
            ALU_OR:  alu_res = a_q | b_q;
            ALU_XOR: alu_res = a_q ^ b_q;
            ALU_SLT: alu_res = {{(`XLEN-1){1'b0}}, ($signed(a_q) < $signed(b_q))};
            default: alu_res = a_q + b_q;
        endcase
    end

    always_ff @(posedge clock) begin
        result_dest <= dest_q;
        result_data <= alu_res;
    end

endmodule

/* instr_decoder.sv */
`include "issue_params.svh"

module instr_decoder import issue_pkg::*; (
    input  instr_word_t            instr,
    output logic [`REG_ADDR_W-1:0] src_a,
    output logic [`REG_ADDR_W-1:0] src_b,
    output logic [`REG_ADDR_W-1:0] dest,
    output logic                   uses_b,
    output logic                   writes_dest,
    output logic                   use_imm,
    output unit_e                  unit,
    output alu_op_e                alu_op,
    output logic [`XLEN-1:0]       imm_value
);

    always_comb begin
        // unknown words fall through as a nop on register 0.
        src_a       = '0;
        src_b       = '0;
        dest        = '0;
        uses_b      = 1'b0;
        writes_dest = 1'b0;
        use_imm     = 1'b0;
        unit        = UNIT_ALU;
        alu_op      = ALU_ADD;
        imm_value   = '0;

        case (instr.r.opcode)
            OP_RTYPE: begin
                if (instr.r.funct inside {FN_ADD, FN_SUB, FN_AND, FN_OR,
                                          FN_XOR, FN_SLT, FN_MUL}) begin
                    src_a       = instr.r.rs;
                    src_b       = instr.r.rt;
                    uses_b      = 1'b1;
                    dest        = instr.r.rd;
                    writes_dest = (instr.r.rd != '0);
                end
                case (instr.r.funct)
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_MUL:  unit = UNIT_MUL;
                    default: alu_op = ALU_ADD;
                endcase
            end
            OP_ADDI: begin
                src_a       = instr.i.rs;
                dest        = instr.i.rt;
                writes_dest = (instr.i.rt != '0);
                use_imm     = 1'b1;
                imm_value   = {{(`XLEN-16){instr.i.imm[15]}}, instr.i.imm};
            end
            OP_ORI: begin
                src_a       = instr.i.rs;
                dest        = instr.i.rt;
                writes_dest = (instr.i.rt != '0);
                use_imm     = 1'b1;
                alu_op      = ALU_OR;
                imm_value   = {{(`XLEN-16){1'b0}}, instr.i.imm};
            end
            default: ;
        endcase
    end

endmodule

/* issue_control.sv */
`include "issue_params.svh"

module issue_control import issue_pkg::*; (
    input  logic                 instr_valid,
    input  logic                 uses_b,
    input  logic                 writes_dest,
    input  unit_e                unit,
    input  logic                 pend_a,
    input  logic                 pend_b,
    input  logic                 pend_dest,
    input  logic [`WB_SLOTS-1:0] slot_busy,
    output logic                 is_stall,
    output logic                 issue_alu,
    output logic                 issue_mul
);

    logic raw_hazard;
    logic waw_hazard;
    logic slot_hazard;
    logic can_issue;

    always_comb begin
        // src_a of a nop is r0, never pending.
        raw_hazard = pend_a || (uses_b && pend_b);
        waw_hazard = writes_dest && pend_dest;

        // only a writing instruction needs a writeback slot.
        if (unit == UNIT_MUL) begin
            slot_hazard = writes_dest && slot_busy[`MUL_LATENCY-1];
        end else begin
            slot_hazard = writes_dest && slot_busy[`ALU_LATENCY-1];
        end

        is_stall  = instr_valid && (raw_hazard || waw_hazard || slot_hazard);
        can_issue = instr_valid && !(raw_hazard || waw_hazard || slot_hazard);
        issue_alu = can_issue && (unit == UNIT_ALU);
        issue_mul = can_issue && (unit == UNIT_MUL);
    end

endmodule

/* issue_params.svh */
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// datapath and register file sizes.
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// result latency of each unit, counted after the operand capture edge.
`define ALU_LATENCY 1
`define MUL_LATENCY 4

// reservation vector covers the longest unit.
`define WB_SLOTS    `MUL_LATENCY

`endif

/* issue_pkg.sv */
package issue_pkg;

    // register format view.
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    // immediate format view.
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_word_t;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_ADDI  = 6'd8,  // sign-extended imm.
        OP_ORI   = 6'd13  // zero-extended imm.
    } opcode_e;

    typedef enum logic [5:0] {
        FN_MUL = 6'd24,
        FN_ADD = 6'd32,
        FN_SUB = 6'd34,
        FN_AND = 6'd36,
        FN_OR  = 6'd37,
        FN_XOR = 6'd38,
        FN_SLT = 6'd42
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic {
        UNIT_ALU,
        UNIT_MUL
    } unit_e;

endpackage

/* issue_top.f */
+incdir+.
issue_pkg.sv
instr_decoder.sv
scoreboard.sv
issue_control.sv
register_file.sv
alu_unit.sv
mul_unit.sv
issue_top.sv
tb_issue_top.sv

/* issue_top.sv */
`include "issue_params.svh"

module issue_top import issue_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   instr_valid,
    input  instr_word_t            instr,
    output logic                   is_stall,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_addr,
    output logic [`XLEN-1:0]       wb_data
);

    logic [`REG_ADDR_W-1:0] src_a;
    logic [`REG_ADDR_W-1:0] src_b;
    logic [`REG_ADDR_W-1:0] dest;
    logic                   uses_b;
    logic                   writes_dest;
    logic                   use_imm;
    unit_e                  unit;
    alu_op_e                alu_op;
    logic [`XLEN-1:0]       imm_value;
    logic [`XLEN-1:0]       rdata_a;
    logic [`XLEN-1:0]       rdata_b;
    logic                   pend_a;
    logic                   pend_b;
    logic                   pend_dest;
    logic [`WB_SLOTS-1:0]   slot_busy;
    logic                   issue_alu;
    logic                   issue_mul;
    logic                   alu_valid;
    logic [`REG_ADDR_W-1:0] alu_dest;
    logic [`XLEN-1:0]       alu_data;
    logic                   mul_valid;
    logic [`REG_ADDR_W-1:0] mul_dest;
    logic [`XLEN-1:0]       mul_data;

    instr_decoder u_decoder (
        .instr(instr), .src_a(src_a), .src_b(src_b), .dest(dest),
        .uses_b(uses_b), .writes_dest(writes_dest), .use_imm(use_imm),
        .unit(unit), .alu_op(alu_op), .imm_value(imm_value)
    );

    scoreboard u_scoreboard (
        .clock(clock), .reset(reset),
        .rd_a(src_a), .rd_b(src_b), .rd_dest(dest),
        .pend_a(pend_a), .pend_b(pend_b), .pend_dest(pend_dest),
        .slot_busy(slot_busy),
        .set_en(issue_alu | issue_mul), .set_addr(dest), .set_unit(unit),
        .clear_en(wb_valid), .clear_addr(wb_addr)
    );

    issue_control u_control (
        .instr_valid(instr_valid), .uses_b(uses_b), .writes_dest(writes_dest),
        .unit(unit), .pend_a(pend_a), .pend_b(pend_b), .pend_dest(pend_dest),
        .slot_busy(slot_busy), .is_stall(is_stall),
        .issue_alu(issue_alu), .issue_mul(issue_mul)
    );

    register_file u_regfile (
        .clock(clock), .reset(reset),
        .raddr_a(src_a), .raddr_b(src_b), .rdata_a(rdata_a), .rdata_b(rdata_b),
        .alu_valid(alu_valid), .mul_valid(mul_valid),
        .alu_dest(alu_dest), .mul_dest(mul_dest),
        .alu_data(alu_data), .mul_data(mul_data),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data)
    );

    alu_unit u_alu (
        .clock(clock), .reset(reset), .issue(issue_alu),
        .op_a(rdata_a), .op_b(rdata_b), .imm_value(imm_value),
        .use_imm(use_imm), .alu_op(alu_op),
        .dest(dest), .writes_dest(writes_dest),
        .result_valid(alu_valid), .result_dest(alu_dest), .result_data(alu_data)
    );

    mul_unit u_mul (
        .clock(clock), .reset(reset), .issue(issue_mul),
        .op_a(rdata_a), .op_b(rdata_b),
        .dest(dest), .writes_dest(writes_dest),
        .result_valid(mul_valid), .result_dest(mul_dest), .result_data(mul_data)
    );

endmodule

/* mul_unit.sv */
`include "issue_params.svh"

module mul_unit (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   issue,
    input  logic [`XLEN-1:0]       op_a,
    input  logic [`XLEN-1:0]       op_b,
    input  logic [`REG_ADDR_W-1:0] dest,
    input  logic                   writes_dest,
    output logic                   result_valid,
    output logic [`REG_ADDR_W-1:0] result_dest,
    output logic [`XLEN-1:0]       result_data
);

    logic                   cap_valid;
    logic [`XLEN-1:0]       a_q;
    logic [`XLEN-1:0]       b_q;
    logic [`REG_ADDR_W-1:0] cap_dest;

    logic                   stage_valid [`MUL_LATENCY];
    logic [`REG_ADDR_W-1:0] stage_dest  [`MUL_LATENCY];
    logic [`XLEN-1:0]       stage_data  [`MUL_LATENCY];

    always_ff @(posedge clock) begin
        if (reset) begin
            cap_valid <= 1'b0;
            for (int i = 0; i < `MUL_LATENCY; i++) begin
                stage_valid[i] <= 1'b0;
            end
        end else begin
            cap_valid      <= issue && writes_dest;
            stage_valid[0] <= cap_valid;
            for (int i = 1; i < `MUL_LATENCY; i++) begin
                stage_valid[i] <= stage_valid[i-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            a_q      <= op_a;
            b_q      <= op_b;
            cap_dest <= dest;
        end
        stage_dest[0] <= cap_dest;
        stage_data[0] <= a_q * b_q; // low word only.
        for (int i = 1; i < `MUL_LATENCY; i++) begin
            stage_dest[i] <= stage_dest[i-1];
            stage_data[i] <= stage_data[i-1];
        end
    end

    assign result_valid = stage_valid[`MUL_LATENCY-1];
    assign result_dest  = stage_dest[`MUL_LATENCY-1];
    assign result_data  = stage_data[`MUL_LATENCY-1];

endmodule

/* register_file.sv */
`include "issue_params.svh"

module register_file (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] raddr_a,
    input  logic [`REG_ADDR_W-1:0] raddr_b,
    output logic [`XLEN-1:0]       rdata_a,
    output logic [`XLEN-1:0]       rdata_b,
    input  logic                   alu_valid,
    input  logic                   mul_valid,
    input  logic [`REG_ADDR_W-1:0] alu_dest,
    input  logic [`REG_ADDR_W-1:0] mul_dest,
    input  logic [`XLEN-1:0]       alu_data,
    input  logic [`XLEN-1:0]       mul_data,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_addr,
    output logic [`XLEN-1:0]       wb_data
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // slot reservation keeps the two results apart.
    assign wb_valid = alu_valid || mul_valid;
    assign wb_addr  = mul_valid ? mul_dest : alu_dest;
    assign wb_data  = mul_valid ? mul_data : alu_data;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && (wb_addr != '0)) begin
            regs[wb_addr] <= wb_data; // r0 is never written.
        end
    end

    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

/* scoreboard.sv */
`include "issue_params.svh"

module scoreboard import issue_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] rd_a,
    input  logic [`REG_ADDR_W-1:0] rd_b,
    input  logic [`REG_ADDR_W-1:0] rd_dest,
    output logic                   pend_a,
    output logic                   pend_b,
    output logic                   pend_dest,
    output logic [`WB_SLOTS-1:0]   slot_busy,
    input  logic                   set_en,
    input  logic [`REG_ADDR_W-1:0] set_addr,
    input  unit_e                  set_unit,
    input  logic                   clear_en,
    input  logic [`REG_ADDR_W-1:0] clear_addr
);

    logic [`NUM_REGS-1:0] pending_q;
    logic [`WB_SLOTS-1:0] slot_q;
    logic [`WB_SLOTS-1:0] slot_next;
    logic                 set_live;
    int                   set_lat;

    assign set_live = set_en && (set_addr != '0); // r0 is never tracked.
    assign set_lat  = (set_unit == UNIT_MUL) ? `MUL_LATENCY : `ALU_LATENCY;

    // bit k means wb_valid is due k+2 cycles from now.
    // A new issue of latency L lands on bit L-1, so after the edge it sits at L-2.
    // An ALU result lands before anything issued later and needs no bit.
    always_comb begin
        slot_next = slot_q >> 1;
        if (set_live && set_lat >= 2) begin
            slot_next[set_lat-2] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pending_q <= '0;
            slot_q    <= '0;
        end else begin
            if (clear_en) begin
                pending_q[clear_addr] <= 1'b0; // writeback retires it.
            end
            if (set_live) begin
                pending_q[set_addr] <= 1'b1;
            end
            slot_q <= slot_next;
        end
    end

    assign pend_a    = pending_q[rd_a];
    assign pend_b    = pending_q[rd_b];
    assign pend_dest = pending_q[rd_dest];
    assign slot_busy = slot_q;

endmodule

/* tb_issue_top.sv */
`include "issue_params.svh"

module tb_issue_top;

    localparam int NUM_INSTRS  = 400;
    localparam int STALL_LIMIT = 20;
    localparam int DRAIN_LIMIT = 40;
    localparam int QUIET_TIME  = 8;

    logic                   clock;
    logic                   reset;
    logic                   instr_valid;
    logic [31:0]            instr;
    logic                   is_stall;
    logic                   wb_valid;
    logic [`REG_ADDR_W-1:0] wb_addr;
    logic [`XLEN-1:0]       wb_data;

    logic [31:0]            lfsr_state;
    logic [`XLEN-1:0]       arch [`NUM_REGS]; // in-order architectural state.
    logic [`REG_ADDR_W-1:0] out_addr [$];
    logic [`XLEN-1:0]       out_data [$];
    int                     value_errors;
    int                     protocol_errors;
    int                     timeout_errors;
    int                     accepted_count;
    int                     wb_count;
    int                     stall_cycles;
    bit                     aborted;

    issue_top u_issue_top (
        .clock(clock), .reset(reset),
        .instr_valid(instr_valid), .instr(instr), .is_stall(is_stall),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data)
    );

    always #50 clock = ~clock;

    // galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int width);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < width; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] random_instr();
        logic [3:0]  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [31:0] word;
        kind = rand_bits(4);
        rs   = rand_bits(3); // r0..r7 keeps hazards frequent.
        rt   = rand_bits(3);
        rd   = rand_bits(3);
        imm  = rand_bits(16);
        case (kind)
            4'd0, 4'd1:       word = {6'd0, rs, rt, rd, 5'd0, 6'd32};
            4'd2:             word = {6'd0, rs, rt, rd, 5'd0, 6'd34};
            4'd3:             word = {6'd0, rs, rt, rd, 5'd0, 6'd36};
            4'd4:             word = {6'd0, rs, rt, rd, 5'd0, 6'd37};
            4'd5:             word = {6'd0, rs, rt, rd, 5'd0, 6'd38};
            4'd6, 4'd7:       word = {6'd0, rs, rt, rd, 5'd0, 6'd42};
            4'd8, 4'd9, 4'd10: word = {6'd0, rs, rt, rd, 5'd0, 6'd24};
            4'd11, 4'd12:     word = {6'd8, rs, rt, imm};
            4'd13, 4'd14:     word = {6'd13, rs, rt, imm};
            default: begin
                if (rand_bits(1) == 1) begin
                    word = {6'd56 | 6'(rand_bits(3)), rs, rt, imm}; // opcodes 56..63 unused.
                end else begin
                    word = {6'd0, rs, rt, rd, 5'd0, 6'(rand_bits(4))}; // functs 0..15 unused.
                end
            end
        endcase
        return word;
    endfunction

    task automatic apply_model(input logic [31:0] w);
        logic [5:0]       opcode;
        logic [4:0]       rs;
        logic [4:0]       rt;
        logic [5:0]       funct;
        logic [15:0]      imm;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] res;
        logic [4:0]       target;
        bit               known;
        opcode = w[31:26];
        rs     = w[25:21];
        rt     = w[20:16];
        funct  = w[5:0];
        imm    = w[15:0];
        a      = arch[rs];
        b      = arch[rt];
        target = w[15:11];
        known  = 1'b1;
        res    = '0;
        case (opcode)
            6'd0: begin
                case (funct)
                    6'd32:   res = a + b;
                    6'd34:   res = a - b;
                    6'd36:   res = a & b;
                    6'd37:   res = a | b;
                    6'd38:   res = a ^ b;
                    6'd42:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'd24:   res = a * b; // low word of the product.
                    default: known = 1'b0;
                endcase
            end
            6'd8: begin
                target = rt;
                res    = a + {{16{imm[15]}}, imm};
            end
            6'd13: begin
                target = rt;
                res    = a | {16'd0, imm};
            end
            default: known = 1'b0;
        endcase
        if (known && target != 0) begin
            arch[target] = res;
            out_addr.push_back(target);
            out_data.push_back(res);
        end
    endtask

    task automatic check_writeback();
        int idx;
        idx = -1;
        if (wb_valid === 1'b1) begin
            wb_count++;
            if (wb_addr == 0) begin
                $display("** Error at %0t: wb_addr expected nonzero, got %0d", $time, wb_addr);
                value_errors++;
            end
            for (int i = 0; i < out_addr.size(); i++) begin
                if (idx < 0 && out_addr[i] == wb_addr) idx = i;
            end
            if (idx < 0) begin
                $display("%0t: writeback to r%0d with no instruction waiting for it",
                         $time, wb_addr);
                protocol_errors++;
            end else begin
                if (wb_data !== out_data[idx]) begin
                    $display("** Error at %0t: wb_data (r%0d) expected %h, got %h",
                             $time, wb_addr, out_data[idx], wb_data);
                    value_errors++;
                end
                out_addr.delete(idx);
                out_data.delete(idx);
            end
        end else if (wb_valid !== 1'b0) begin
            $display("%0t: wb_valid is unknown", $time);
            protocol_errors++;
        end
    endtask

    task automatic step_clock();
        @(posedge clock);
        check_writeback();
    endtask

    initial begin
        int waited;
        bit accepted;
        clock           = 1'b0;
        reset           = 1'b1;
        instr_valid     = 1'b0;
        instr           = '0;
        lfsr_state      = 32'd92427;
        value_errors    = 0;
        protocol_errors = 0;
        timeout_errors  = 0;
        accepted_count  = 0;
        wb_count        = 0;
        stall_cycles    = 0;
        aborted         = 1'b0;
        for (int r = 0; r < `NUM_REGS; r++) begin
            arch[r] = '0;
        end

        repeat (16) @(posedge clock);
        reset <= 1'b0;

        // idle cycles after reset.
        repeat (4) begin
            @(posedge clock);
            if (is_stall !== 1'b0) begin
                $display("** Error at %0t: is_stall expected 0, got %b", $time, is_stall);
                value_errors++;
            end
            if (wb_valid !== 1'b0) begin
                $display("** Error at %0t: wb_valid expected 0, got %b", $time, wb_valid);
                value_errors++;
            end
        end

        for (int n = 0; n < NUM_INSTRS && !aborted; n++) begin
            if (rand_bits(2) == 0) begin
                instr_valid <= 1'b0;
                step_clock();
            end else begin
                instr_valid <= 1'b1;
                instr       <= random_instr();
                accepted = 1'b0;
                waited   = 0;
                while (!accepted && waited < STALL_LIMIT) begin
                    step_clock();
                    if (is_stall === 1'b0) begin
                        accepted = 1'b1;
                    end else begin
                        waited++;
                        stall_cycles++;
                    end
                end
                if (accepted) begin
                    apply_model(instr);
                    accepted_count++;
                end else begin
                    $display("%0t: instruction %h still stalled after %0d cycles",
                             $time, instr, STALL_LIMIT);
                    timeout_errors++;
                    aborted = 1'b1;
                end
            end
        end

        instr_valid <= 1'b0;
        waited = 0;
        while (!aborted && out_addr.size() > 0 && waited < DRAIN_LIMIT) begin
            step_clock();
            waited++;
        end
        if (!aborted && out_addr.size() > 0) begin
            $display("%0t: %0d writebacks never arrived, first one for r%0d",
                     $time, out_addr.size(), out_addr[0]);
            timeout_errors++;
        end

        // stray writebacks would show up here.
        waited = 0;
        while (!aborted && waited < QUIET_TIME) begin
            step_clock();
            waited++;
        end

        $display("accepted %0d, writebacks %0d, stall cycles %0d",
                 accepted_count, wb_count, stall_cycles);
        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
